/* files.f */
+incdir+logic
logic/marble_ctrl_pkg.sv
logic/scrap_if.sv
logic/scrap_decode.sv
logic/scrap_execute.sv
logic/scrap_result.sv
logic/test_pattern_gen.sv
logic/marble_ctrl_top.sv
verification/marble_ctrl_tb.sv

/* verification/marble_ctrl_tb.sv */
// ##############################
// Each request is checked two edges after it is driven
// Config bit 0 is taken as the pattern enable
// ##############################
`include "marble_ctrl_macros.svh"

module marble_ctrl_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// Expected DUT state after one request
	typedef struct packed {
		logic [`SCRAP_DATA_W-1:0] rdata;
		logic [`IDELAY_TAP_W-1:0] tap;
		logic [2:0]               cfg;
		logic [`LED_W-1:0]        leds;
		logic                     ce;
	} exp_t;

	logic                     tx_clk;
	logic                     arst_n;
	logic [`SCRAP_ADDR_W-1:0] scrap_addr;
	logic [`SCRAP_DATA_W-1:0] scrap_wdata;
	logic                     scrap_we;
	logic [1:0]               scrap_op;
	logic [`SCRAP_DATA_W-1:0] scrap_rdata;
	logic [`IDELAY_TAP_W-1:0] idelay_value;
	logic                     idelay_ce;
	logic [`LED_W-1:0]        leds;
	logic                     vcxo_en;
	logic                     idelayctrl_reset;
	logic [3:0]               pattern_out;

	// Register model
	logic [`IDELAY_TAP_W-1:0] m_tap;
	logic [2:0]               m_cfg;
	logic [`LED_W-1:0]        m_leds;
	logic [`SCRAP_DATA_W-1:0] m_scratch;

	// Requests in flight, oldest first
	exp_t exp_q[$];
	logic [31:0] lcg_state;
	int check_count;
	int error_count;
	int test_errors[1:5];

	marble_ctrl_top i_marble_ctrl_top (
		.tx_clk           (tx_clk),
		.arst_n           (arst_n),
		.scrap_addr       (scrap_addr),
		.scrap_wdata      (scrap_wdata),
		.scrap_we         (scrap_we),
		.scrap_op         (scrap_op),
		.scrap_rdata      (scrap_rdata),
		.idelay_value     (idelay_value),
		.idelay_ce        (idelay_ce),
		.leds             (leds),
		.vcxo_en          (vcxo_en),
		.idelayctrl_reset (idelayctrl_reset),
		.pattern_out      (pattern_out)
	);

	// 40 ns period
	always #20 tx_clk = ~tx_clk;

	// LCG, upper half gives the better bits
	function logic [15:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	// Write, set, clear and toggle as seen by the host
	function automatic logic [15:0] op_rule(input logic [1:0] op, input logic [15:0] cur,
			input logic [15:0] data);
		case (op)
			marble_ctrl_pkg::OP_WRITE: return data;
			marble_ctrl_pkg::OP_SET:   return cur | data;
			marble_ctrl_pkg::OP_CLEAR: return cur & ~data;
			default:                   return cur ^ data;
		endcase
	endfunction

	// One LFSR step, feedback from bits 3 and 2
	function automatic logic [3:0] lfsr_step(input logic [3:0] v);
		return {v[2:0], v[3] ^ v[2]};
	endfunction

	task automatic check_value(input string name, input logic [15:0] exp,
			input logic [15:0] act, input int id);
		check_count++;
		assert (act === exp) else begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			error_count++;
			test_errors[id]++;
		end
	endtask

	task automatic report_failure(input string msg, input int id);
		$display("Failure: %s", msg);
		error_count++;
		test_errors[id]++;
	endtask

	task automatic report_test(input string name, input int id);
		$display("Test %0d %s finished with %0d errors", id, name, test_errors[id]);
	endtask

	// Apply one request to the model, return the expected readback
	task automatic apply_model(input logic [7:0] a, input logic [1:0] o, input logic w,
			input logic [15:0] d, output logic [15:0] rd);
		logic [15:0] cur;
		logic [15:0] mask;
		logic [15:0] nv;
		case (a)
			`REG_ADDR_IDELAY:  begin cur = m_tap;     mask = 16'h001f; end
			`REG_ADDR_CONFIG:  begin cur = m_cfg;     mask = 16'h0007; end
			`REG_ADDR_LEDS:    begin cur = m_leds;    mask = 16'h00ff; end
			`REG_ADDR_SCRATCH: begin cur = m_scratch; mask = 16'hffff; end
			default:           begin cur = '0;        mask = 16'h0000; end
		endcase
		// Data is trimmed to the register before the operation
		nv = op_rule(o, cur, d & mask) & mask;
		rd = w ? nv : cur;
		if (w) begin
			case (a)
				`REG_ADDR_IDELAY:  m_tap = nv[`IDELAY_TAP_W-1:0];
				`REG_ADDR_CONFIG:  m_cfg = nv[2:0];
				`REG_ADDR_LEDS:    m_leds = nv[`LED_W-1:0];
				`REG_ADDR_SCRATCH: m_scratch = nv;
				default:           ;
			endcase
		end
	endtask

	task automatic drive_req(input logic [7:0] a, input logic [1:0] o, input logic w,
			input logic [15:0] d);
		@(posedge tx_clk);
		scrap_addr <= a;
		scrap_op <= o;
		scrap_we <= w;
		scrap_wdata <= d;
	endtask

	// Back to back random requests, last two are reads to flush the pipe
	task automatic run_random(input int count);
		exp_t e;
		logic [15:0] r;
		logic [7:0] a;
		logic [1:0] o;
		logic w;
		logic [15:0] d;
		logic [15:0] rd;
		int i;
		for (i = 0; i < count + 2; i++) begin
			r = next_rand();
			a = r % 6;
			o = r[5:4];
			w = (r[10:8] != 3'd0) && (i < count);
			d = next_rand();
			drive_req(a, o, w, d);
			apply_model(a, o, w, d, rd);
			e.rdata = rd;
			e.tap = m_tap;
			e.cfg = m_cfg;
			e.leds = m_leds;
			e.ce = w && (a == `REG_ADDR_IDELAY);
			exp_q.push_back(e);
			@(negedge tx_clk);
			// Outputs now reflect the request from two edges back
			if (exp_q.size() > 2) begin
				e = exp_q.pop_front();
				check_value("scrap_rdata", e.rdata, scrap_rdata, 2);
				check_value("idelay_value", e.tap, idelay_value, 3);
				check_value("idelay_ce", e.ce, idelay_ce, 3);
				check_value("leds", e.leds, leds, 4);
				check_value("vcxo_en", !e.cfg[1], vcxo_en, 4);
				check_value("idelayctrl_reset", e.cfg[2], idelayctrl_reset, 4);
				if (!e.cfg[0])
					check_value("pattern_out", 16'h0, pattern_out, 5);
			end
		end
	endtask

	task automatic run_pattern();
		logic [3:0] prev;
		int t;
		// Start from a clean config, then enable
		drive_req(`REG_ADDR_CONFIG, marble_ctrl_pkg::OP_WRITE, 1'b1, 16'h0000);
		drive_req(`REG_ADDR_CONFIG, marble_ctrl_pkg::OP_SET, 1'b1, 16'h0001);
		drive_req(8'd5, marble_ctrl_pkg::OP_WRITE, 1'b0, 16'h0000);
		t = 0;
		@(negedge tx_clk);
		while ((pattern_out == 4'd0) && (t < 10)) begin
			@(negedge tx_clk);
			t++;
		end
		check_count++;
		assert (pattern_out != 4'd0) else
			report_failure("pattern_out stayed zero after the pattern was enabled", 5);
		if (pattern_out != 4'd0) begin
			check_value("pattern_out", `PATTERN_SEED, pattern_out, 5);
			repeat (20) begin
				prev = pattern_out;
				@(negedge tx_clk);
				check_value("pattern_out", lfsr_step(prev), pattern_out, 5);
			end
		end
		// Clearing the enable must bring the output back to zero
		drive_req(`REG_ADDR_CONFIG, marble_ctrl_pkg::OP_CLEAR, 1'b1, 16'h0001);
		drive_req(8'd5, marble_ctrl_pkg::OP_WRITE, 1'b0, 16'h0000);
		t = 0;
		@(negedge tx_clk);
		while ((pattern_out != 4'd0) && (t < 10)) begin
			@(negedge tx_clk);
			t++;
		end
		check_count++;
		assert (pattern_out == 4'd0) else
			report_failure("pattern_out did not return to zero after the enable was cleared", 5);
	endtask

	initial begin
		tx_clk = 1'b0;
		arst_n = 1'b0;
		scrap_addr = '0;
		scrap_wdata = '0;
		scrap_we = 1'b0;
		scrap_op = '0;
		m_tap = '0;
		m_cfg = '0;
		m_leds = '0;
		m_scratch = '0;
		lcg_state = 32'd32;
		check_count = 0;
		error_count = 0;
		foreach (test_errors[k])
			test_errors[k] = 0;

		// Reset for 8 cycles
		repeat (8) @(posedge tx_clk);
		arst_n <= 1'b1;
		@(negedge tx_clk);
		check_value("scrap_rdata", 16'h0, scrap_rdata, 1);
		check_value("idelay_ce", 16'h0, idelay_ce, 1);
		check_value("leds", 16'h0, leds, 1);
		check_value("pattern_out", 16'h0, pattern_out, 1);
		check_value("idelay_value", 16'h0, idelay_value, 1);
		check_value("vcxo_en", 16'h1, vcxo_en, 1);
		report_test("reset values", 1);

		run_random(400);
		report_test("write and readback", 2);
		report_test("IDELAY load", 3);
		report_test("board outputs", 4);

		run_pattern();
		report_test("test pattern", 5);

		$display("Checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* logic/marble_ctrl_top.sv */
// ##############################
// Single clock tx_clk; reads lag requests by two edges
// ##############################
`include "marble_ctrl_macros.svh"

module marble_ctrl_top (
	input  logic                     tx_clk,
	input  logic                     arst_n,
	input  logic [`SCRAP_ADDR_W-1:0] scrap_addr,
	input  logic [`SCRAP_DATA_W-1:0] scrap_wdata,
	input  logic                     scrap_we,
	input  logic [1:0]               scrap_op,
	output logic [`SCRAP_DATA_W-1:0] scrap_rdata,
	output logic [`IDELAY_TAP_W-1:0] idelay_value,
	output logic                     idelay_ce,
	output logic [`LED_W-1:0]        leds,
	output logic                     vcxo_en,
	output logic                     idelayctrl_reset,
	output logic [3:0]               pattern_out
);

	// Stage links
	scrap_req_if req_if ();
	reg_view_if view_if ();

	// Address decode and request register
	scrap_decode i_scrap_decode (
		.tx_clk (tx_clk),
		.arst_n (arst_n),
		.addr   (scrap_addr),
		.wdata  (scrap_wdata),
		.we     (scrap_we),
		.op     (marble_ctrl_pkg::scrap_op_e'(scrap_op)),
		.req    (req_if.decode_mp)
	);

	// Control registers
	scrap_execute i_scrap_execute (
		.tx_clk    (tx_clk),
		.arst_n    (arst_n),
		.req       (req_if.execute_mp),
		.regs      (view_if.owner_mp),
		.idelay_ce (idelay_ce)
	);

	// Readback register
	scrap_result i_scrap_result (
		.tx_clk (tx_clk),
		.arst_n (arst_n),
		.req    (req_if.result_mp),
		.regs   (view_if.reader_mp),
		.rdata  (scrap_rdata)
	);

	// Test pattern, gated by config bit 0
	test_pattern_gen i_test_pattern_gen (
		.tx_clk  (tx_clk),
		.arst_n  (arst_n),
		.enable  (view_if.cfg.pattern_en),
		.pattern (pattern_out)
	);

	// Board controls straight from the registers
	assign idelay_value = view_if.idelay_tap;
	assign leds = view_if.leds;
	assign idelayctrl_reset = view_if.cfg.idelayctrl_reset;
	// VCXO runs unless the host turns it off
	assign vcxo_en = ~view_if.cfg.vcxo_off;

endmodule

/* logic/test_pattern_gen.sv */
// ##############################
// Zero while disabled, reseeds on each enable
// ##############################
`include "marble_ctrl_macros.svh"

module test_pattern_gen (
	input  logic       tx_clk,
	input  logic       arst_n,
	input  logic       enable,
	output logic [3:0] pattern
);

	// Shift register, zero means not yet seeded
	logic [3:0] lfsr;

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			lfsr <= '0;
		end else if (!enable) begin
			// Cleared so the next enable reloads the seed
			lfsr <= '0;
		end else if (lfsr == 4'd0) begin
			lfsr <= `PATTERN_SEED;
		end else begin
			// Shift left, feedback from bits 3 and 2
			// A nonzero state never returns to zero
			lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
		end
	end

	// Output forced low as soon as enable drops
	assign pattern = enable ? lfsr : 4'd0;

endmodule

/* logic/scrap_result.sv */
// ##############################
// Readback includes the request's own write
// ##############################
`include "marble_ctrl_macros.svh"

module scrap_result (
	input  logic                     tx_clk,
	input  logic                     arst_n,
	scrap_req_if.result_mp           req,
	reg_view_if.reader_mp            regs,
	output logic [`SCRAP_DATA_W-1:0] rdata
);

	localparam int TAP_PAD = `SCRAP_DATA_W - `IDELAY_TAP_W;
	localparam int LED_PAD = `SCRAP_DATA_W - `LED_W;

	// Selected register and its data view, zero-extended
	logic [`SCRAP_DATA_W-1:0] cur;
	logic [`SCRAP_DATA_W-1:0] dat;
	logic [`SCRAP_DATA_W-1:0] nxt;

	always_comb begin
		cur = '0;
		dat = '0;
		if (req.sel.idelay) begin
			cur = {{TAP_PAD{1'b0}}, regs.idelay_tap};
			dat = {{TAP_PAD{1'b0}}, req.data.tap.tap};
		end else if (req.sel.cfg) begin
			cur = regs.cfg;
			dat = marble_ctrl_pkg::cfg_only(req.data.cfg);
		end else if (req.sel.leds) begin
			cur = {{LED_PAD{1'b0}}, regs.leds};
			dat = {{LED_PAD{1'b0}}, req.data.raw[`LED_W-1:0]};
		end else if (req.sel.scratch) begin
			cur = regs.scratch;
			dat = req.data.raw;
		end
		// Zero padding survives every operation
		// Unmapped stays zero as both inputs are zero
		nxt = req.we ? marble_ctrl_pkg::apply_op(req.op, cur, dat) : cur;
	end

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			rdata <= '0;
		end else begin
			rdata <= nxt;
		end
	end

endmodule

/* logic/scrap_execute.sv */
// ##############################
// Registers keep their own width; reserved bits stay zero
// ##############################
`include "marble_ctrl_macros.svh"

module scrap_execute (
	input  logic            tx_clk,
	input  logic            arst_n,
	scrap_req_if.execute_mp req,
	reg_view_if.owner_mp    regs,
	output logic            idelay_ce
);

	localparam int TAP_PAD = `SCRAP_DATA_W - `IDELAY_TAP_W;
	localparam int LED_PAD = `SCRAP_DATA_W - `LED_W;

	// Candidate values are 16 bits wide before trimming
	logic [`SCRAP_DATA_W-1:0] tap_word;
	logic [`SCRAP_DATA_W-1:0] cfg_word;
	logic [`SCRAP_DATA_W-1:0] led_word;
	logic [`SCRAP_DATA_W-1:0] scr_word;

	// Each register sees the matching view of the data
	always_comb begin
		// IDELAY uses the tap field only
		tap_word = marble_ctrl_pkg::apply_op(
			req.op,
			{{TAP_PAD{1'b0}}, regs.idelay_tap},
			{{TAP_PAD{1'b0}}, req.data.tap.tap}
		);
		// Config uses the three field bits
		cfg_word = marble_ctrl_pkg::apply_op(
			req.op,
			regs.cfg,
			marble_ctrl_pkg::cfg_only(req.data.cfg)
		);
		// LEDs take the low byte of the raw word
		led_word = marble_ctrl_pkg::apply_op(
			req.op,
			{{LED_PAD{1'b0}}, regs.leds},
			{{LED_PAD{1'b0}}, req.data.raw[`LED_W-1:0]}
		);
		scr_word = marble_ctrl_pkg::apply_op(req.op, regs.scratch, req.data.raw);
	end

	// Register file where one register changes per request
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			regs.idelay_tap <= '0;
			regs.cfg <= '0;
			regs.leds <= '0;
			regs.scratch <= '0;
		end else if (req.we) begin
			if (req.sel.idelay) begin
				regs.idelay_tap <= tap_word[`IDELAY_TAP_W-1:0];
			end
			if (req.sel.cfg) begin
				// Reserved bits are already zero here
				regs.cfg <= cfg_word;
			end
			if (req.sel.leds) begin
				regs.leds <= led_word[`LED_W-1:0];
			end
			if (req.sel.scratch) begin
				regs.scratch <= scr_word;
			end
		end
	end

	// Load pulse on every IDELAY write
	// Same edge as the new tap value
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			idelay_ce <= 1'b0;
		end else begin
			idelay_ce <= req.we & req.sel.idelay;
		end
	end

endmodule

/* logic/scrap_decode.sv */
// ##############################
// Unmapped writes keep we with an empty select
// ##############################
`include "marble_ctrl_macros.svh"

module scrap_decode (
	input  logic                       tx_clk,
	input  logic                       arst_n,
	input  logic [`SCRAP_ADDR_W-1:0]   addr,
	input  logic [`SCRAP_DATA_W-1:0]   wdata,
	input  logic                       we,
	input  marble_ctrl_pkg::scrap_op_e op,
	scrap_req_if.decode_mp             req
);

	// Address match, at most one bit set
	marble_ctrl_pkg::reg_sel_t sel_d;

	always_comb begin
		sel_d = '0;
		// Compare against each mapped register
		sel_d.idelay = (addr == `REG_ADDR_IDELAY);
		sel_d.cfg = (addr == `REG_ADDR_CONFIG);
		sel_d.leds = (addr == `REG_ADDR_LEDS);
		sel_d.scratch = (addr == `REG_ADDR_SCRATCH);
	end

	// Control part of the request
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			req.sel <= '0;
			req.op <= marble_ctrl_pkg::OP_WRITE;
			req.we <= 1'b0;
		end else begin
			req.sel <= sel_d;
			req.op <= op;
			// Strobe lasts exactly one cycle
			req.we <= we;
		end
	end

	// Data word, viewed later per register
	always_ff @(posedge tx_clk) begin
		req.data.raw <= wdata;
	end

endmodule

/* logic/scrap_if.sv */
// ##############################
// Request valid for one cycle after sampling, no handshake
// ##############################
`include "marble_ctrl_macros.svh"

// Decoded request between the pipeline stages
interface scrap_req_if;
	marble_ctrl_pkg::reg_sel_t sel;
	marble_ctrl_pkg::scrap_op_e op;
	logic we;
	marble_ctrl_pkg::scrap_word_u data;

	// Decode stage produces the request
	modport decode_mp (
		output sel,
		output op,
		output we,
		output data
	);

	// Register file applies it
	modport execute_mp (
		input sel,
		input op,
		input we,
		input data
	);

	// Readback predicts the same update
	modport result_mp (
		input sel,
		input op,
		input we,
		input data
	);
endinterface

// Current register contents
interface reg_view_if;
	logic [`IDELAY_TAP_W-1:0] idelay_tap;
	marble_ctrl_pkg::cfg_fields_t cfg;
	logic [`LED_W-1:0] leds;
	logic [`SCRAP_DATA_W-1:0] scratch;

	modport owner_mp (output idelay_tap, output cfg, output leds, output scratch);
	modport reader_mp (input idelay_tap, input cfg, input leds, input scratch);
endinterface

/* logic/marble_ctrl_pkg.sv */
// ##############################
// Types of the scrap bus; field layouts assume 16-bit data
// ##############################
`include "marble_ctrl_macros.svh"

package marble_ctrl_pkg;

	// Write operation carried with every request
	typedef enum logic [1:0] {
		OP_WRITE  = 2'd0,
		OP_SET    = 2'd1,
		OP_CLEAR  = 2'd2,
		OP_TOGGLE = 2'd3
	} scrap_op_e;

	// External configuration bits, pattern_en is bit 0
	typedef struct packed {
		logic [`SCRAP_DATA_W-4:0] reserved;
		logic idelayctrl_reset;
		logic vcxo_off;
		logic pattern_en;
	} cfg_fields_t;

	// IDELAY tap sits in the low bits
	typedef struct packed {
		logic [`SCRAP_DATA_W-`IDELAY_TAP_W-1:0] unused;
		logic [`IDELAY_TAP_W-1:0] tap;
	} tap_fields_t;

	// One data word, read per selected register
	typedef union packed {
		logic [`SCRAP_DATA_W-1:0] raw;
		cfg_fields_t cfg;
		tap_fields_t tap;
	} scrap_word_u;

	// One-hot register select, all zero when unmapped
	typedef struct packed {
		logic scratch;
		logic leds;
		logic cfg;
		logic idelay;
	} reg_sel_t;

	// Common update rule of execute and readback
	function automatic logic [`SCRAP_DATA_W-1:0] apply_op(
		input scrap_op_e op,
		input logic [`SCRAP_DATA_W-1:0] cur,
		input logic [`SCRAP_DATA_W-1:0] data
	);
		case (op)
			OP_WRITE: apply_op = data;
			OP_SET:   apply_op = cur | data;
			OP_CLEAR: apply_op = cur & ~data;
			default:  apply_op = cur ^ data;
		endcase
	endfunction

	// Keeps only the three real configuration bits
	function automatic cfg_fields_t cfg_only(input cfg_fields_t c);
		cfg_only = '0;
		cfg_only.pattern_en = c.pattern_en;
		cfg_only.vcxo_off = c.vcxo_off;
		cfg_only.idelayctrl_reset = c.idelayctrl_reset;
	endfunction

endpackage

/* logic/marble_ctrl_macros.svh */
// ##############################
// Bus widths and register map of the scrap bus
// Any address not listed here reads as zero
// ##############################
`ifndef MARBLE_CTRL_MACROS_SVH
`define MARBLE_CTRL_MACROS_SVH

// Scrap bus widths
`define SCRAP_ADDR_W 8
`define SCRAP_DATA_W 16

// Board control widths
`define IDELAY_TAP_W 5
`define LED_W 8

// Register map
`define REG_ADDR_IDELAY 8'd0
`define REG_ADDR_CONFIG 8'd1
`define REG_ADDR_LEDS 8'd2
`define REG_ADDR_SCRATCH 8'd3

// LFSR start value, must be nonzero
`define PATTERN_SEED 4'b0001

`endif
